// File: verilog/exec_pkg.sv
package exec_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_addr_t;

   // Unlisted codes are no-ops and write nothing
   typedef enum logic [3:0] {
      OP_ADD  = 4'h0,
      OP_SUB  = 4'h1,
      OP_AND  = 4'h2,
      OP_OR   = 4'h3,
      OP_XOR  = 4'h4,
      OP_SLT  = 4'h5, // Signed compare
      OP_ADDI = 4'h6,
      OP_MUL  = 4'h7
   } op_t;

   // Layout of the APB write data at ISSUE_ADDR
   typedef struct packed {
      op_t              op;
      reg_addr_t        rd;
      reg_addr_t        rs1;
      reg_addr_t        rs2;
      logic signed [12:0] imm; // OP_ADDI only
   } instr_t;

   // Resolved operands with b holding the immediate for OP_ADDI
   typedef struct packed {
      logic      valid;
      op_t       op;
      reg_addr_t rd;
      word_t     a;
      word_t     b;
   } issue_t;

   typedef struct packed {
      logic      valid;
      reg_addr_t dst;
      word_t     data;
   } wb_t;

   // APB address map
   localparam int APB_AW = 12;
   localparam logic [APB_AW-1:0] ISSUE_ADDR = 12'h000;
   localparam logic [APB_AW-1:0] REG_BASE   = 12'h400; // r at REG_BASE + 4*r

endpackage

// File: verilog/apb_issue_ctrl.sv
`timescale 1ns/1ps

module apb_issue_ctrl import exec_pkg::*; (
   input  logic              clk,
   input  logic              if_id_reset,
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  logic [APB_AW-1:0] paddr,
   input  word_t             pwdata,
   output word_t             prdata,
   output logic              pready,
   output logic              pslverr,
   output reg_addr_t         rs1_addr,
   output reg_addr_t         rs2_addr,
   output reg_addr_t         dbg_addr,
   input  word_t             rs1_data,
   input  word_t             rs2_data,
   input  word_t             dbg_data,
   input  logic [31:0]       pending,
   input  logic              wb_next,
   output issue_t            issue
);

   typedef enum logic [1:0] {
      IDLE,
      ACCESS,
      STALL
   } state_t;

   state_t state_q;
   state_t state_d;
   instr_t instr;
   logic   in_access;
   logic   is_issue;
   logic   in_window;
   logic   wr_hazard;
   logic   rd_hazard;
   logic   stall;

   assign instr = instr_t'(pwdata);

   // Address decode
   assign is_issue  = (paddr == ISSUE_ADDR);
   assign in_window = (paddr[APB_AW-1:7] == REG_BASE[APB_AW-1:7]) && (paddr[1:0] == 2'b00);

   assign rs1_addr = instr.rs1;
   assign rs2_addr = instr.rs2;
   assign dbg_addr = paddr[6:2];

   // pending[0] is never set, so r0 needs no special case here
   assign wr_hazard = pending[instr.rd] | pending[instr.rs1] | pending[instr.rs2]
                      | ((instr.op != OP_MUL) & wb_next); // ALU result would meet mul_wb
   assign rd_hazard = pending[dbg_addr];

   assign stall = pwrite ? (is_issue & wr_hazard) : (in_window & rd_hazard);

   assign in_access = (state_q != IDLE) && psel && penable;
   assign pready    = in_access && !stall;
   assign pslverr   = pready && (pwrite ? !is_issue : !in_window);
   assign prdata    = (pready && !pwrite && in_window) ? dbg_data : '0;

   always_comb begin
      issue.valid = pready && pwrite && is_issue; // Exactly the completing cycle
      issue.op    = instr.op;
      issue.rd    = instr.rd;
      issue.a     = rs1_data;
      if (instr.op == OP_ADDI) begin
         issue.b = {{19{instr.imm[12]}}, instr.imm};
      end else begin
         issue.b = rs2_data;
      end
   end

   // APB phase tracking
   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (psel && !penable) state_d = ACCESS; // Setup phase seen
         end
         ACCESS, STALL: begin
            if (pready || !psel) state_d = IDLE;
            else                 state_d = STALL;
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Master must hold the transfer while we stall it
   a_stall_stable: assert property (@(posedge clk) disable iff (if_id_reset)
      (state_q == STALL) |-> $stable(paddr) && $stable(pwrite) && $stable(pwdata));

   a_penable_psel: assert property (@(posedge clk) disable iff (if_id_reset)
      $rose(penable) |-> psel);

endmodule

// File: verilog/regfile.sv
`timescale 1ns/1ps

module regfile import exec_pkg::*; (
   input  logic      clk,
   input  logic      if_id_reset,
   input  reg_addr_t rs1_addr,
   input  reg_addr_t rs2_addr,
   input  reg_addr_t dbg_addr,
   output word_t     rs1_data,
   output word_t     rs2_data,
   output word_t     dbg_data,
   input  wb_t       alu_wb,
   input  wb_t       mul_wb
);

   word_t regs [32];
   wb_t   wr;

   // The two sources are kept apart by the issue stall
   assign wr = alu_wb.valid ? alu_wb : mul_wb;

   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wr.valid && (wr.dst != '0)) begin
         regs[wr.dst] <= wr.data;
      end
   end

   // r0 hardwired to zero
   assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
   assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];
   assign dbg_data = (dbg_addr == '0) ? '0 : regs[dbg_addr];

   a_single_writer: assert property (@(posedge clk) disable iff (if_id_reset)
      !(alu_wb.valid && mul_wb.valid));

endmodule

// File: verilog/alu_stage.sv
`timescale 1ns/1ps

module alu_stage import exec_pkg::*; (
   input  logic   clk,
   input  logic   if_id_reset,
   input  issue_t issue,
   output wb_t    alu_wb
);

   word_t result;
   logic  known;

   always_comb begin
      known  = 1'b1;
      result = '0;
      case (issue.op)
         OP_ADD,
         OP_ADDI: result = issue.a + issue.b; // b is the immediate for ADDI
         OP_SUB:  result = issue.a - issue.b;
         OP_AND:  result = issue.a & issue.b;
         OP_OR:   result = issue.a | issue.b;
         OP_XOR:  result = issue.a ^ issue.b;
         OP_SLT:  result = {31'b0, $signed(issue.a) < $signed(issue.b)};
         default: known  = 1'b0; // OP_MUL and unknown codes
      endcase
   end

   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         alu_wb.valid <= 1'b0;
      end else begin
         alu_wb.valid <= issue.valid && known;
      end
      alu_wb.dst  <= issue.rd;
      alu_wb.data <= result;
   end

endmodule

// File: verilog/mult_pipe.sv
`timescale 1ns/1ps

module mult_pipe import exec_pkg::*; #(
   parameter int STAGES = 5 // 2 or more
) (
   input  logic        clk,
   input  logic        if_id_reset,
   input  issue_t      issue,
   output wb_t         mul_wb,
   output logic [31:0] pending,
   output logic        wb_next
);

   wb_t [STAGES-1:0] stage_q;

   always_ff @(posedge clk) begin
      // Low half of the product is all that is kept
      stage_q[0].dst  <= issue.rd;
      stage_q[0].data <= issue.a * issue.b;
      for (int i = 1; i < STAGES; i++) begin
         stage_q[i].dst  <= stage_q[i-1].dst;
         stage_q[i].data <= stage_q[i-1].data;
      end
      if (if_id_reset) begin
         for (int i = 0; i < STAGES; i++) begin
            stage_q[i].valid <= 1'b0;
         end
      end else begin
         stage_q[0].valid <= issue.valid && (issue.op == OP_MUL);
         for (int i = 1; i < STAGES; i++) begin
            stage_q[i].valid <= stage_q[i-1].valid;
         end
      end
   end

   // Destinations still to be written, last stage included
   always_comb begin
      pending = '0;
      for (int i = 0; i < STAGES; i++) begin
         if (stage_q[i].valid) pending[stage_q[i].dst] = 1'b1;
      end
      pending[0] = 1'b0; // r0 is never a hazard
   end

   assign wb_next = stage_q[STAGES-2].valid; // mul_wb on the next edge
   assign mul_wb  = stage_q[STAGES-1];

   // Issue side must have held off any instruction touching an in-flight rd
   a_no_pending_rd: assert property (@(posedge clk) disable iff (if_id_reset)
      issue.valid |-> !pending[issue.rd]);

endmodule

// File: verilog/exec_core.sv
`timescale 1ns/1ps

module exec_core import exec_pkg::*; #(
   parameter int STAGES = 5
) (
   input  logic              clk,
   input  logic              if_id_reset,
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  logic [APB_AW-1:0] paddr,
   input  word_t             pwdata,
   output word_t             prdata,
   output logic              pready,
   output logic              pslverr
);

   reg_addr_t   rs1_addr;
   reg_addr_t   rs2_addr;
   reg_addr_t   dbg_addr;
   word_t       rs1_data;
   word_t       rs2_data;
   word_t       dbg_data;
   logic [31:0] pending;
   logic        wb_next;
   issue_t      issue;
   wb_t         alu_wb;
   wb_t         mul_wb;

   apb_issue_ctrl apb_issue_ctrl_i (
      .clk         (clk),
      .if_id_reset (if_id_reset),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .pwdata      (pwdata),
      .prdata      (prdata),
      .pready      (pready),
      .pslverr     (pslverr),
      .rs1_addr    (rs1_addr),
      .rs2_addr    (rs2_addr),
      .dbg_addr    (dbg_addr),
      .rs1_data    (rs1_data),
      .rs2_data    (rs2_data),
      .dbg_data    (dbg_data),
      .pending     (pending),
      .wb_next     (wb_next),
      .issue       (issue)
   );

   regfile regfile_i (
      .clk         (clk),
      .if_id_reset (if_id_reset),
      .rs1_addr    (rs1_addr),
      .rs2_addr    (rs2_addr),
      .dbg_addr    (dbg_addr),
      .rs1_data    (rs1_data),
      .rs2_data    (rs2_data),
      .dbg_data    (dbg_data),
      .alu_wb      (alu_wb),
      .mul_wb      (mul_wb)
   );

   alu_stage alu_stage_i (
      .clk         (clk),
      .if_id_reset (if_id_reset),
      .issue       (issue),
      .alu_wb      (alu_wb)
   );

   mult_pipe #(
      .STAGES (STAGES)
   ) mult_pipe_i (
      .clk         (clk),
      .if_id_reset (if_id_reset),
      .issue       (issue),
      .mul_wb      (mul_wb),
      .pending     (pending),
      .wb_next     (wb_next)
   );

endmodule

// File: testbench/tb_exec_core.sv
`timescale 1ns/1ps

module tb_exec_core import exec_pkg::*; ();

   localparam int NUM_XFERS = 150; // APB transfers over all tests
   localparam int MAX_CYCLES = 40 * NUM_XFERS;

   logic              clk = 1'b0;
   logic              if_id_reset;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [APB_AW-1:0] paddr;
   word_t             pwdata;
   word_t             prdata;
   logic              pready;
   logic              pslverr;

   logic        xfer_done;
   logic        xfer_err;
   word_t       xfer_rdata;
   int unsigned cycles = 0;
   word_t       exp_regs [32]; // Expected register contents

   exec_core #(
      .STAGES (5)
   ) exec_core_i (
      .clk         (clk),
      .if_id_reset (if_id_reset),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .pwdata      (pwdata),
      .prdata      (prdata),
      .pready      (pready),
      .pslverr     (pslverr)
   );

   always #10 clk = ~clk;

   // Completion sampled on the rising edge for the driver
   always @(posedge clk) begin
      xfer_done  <= psel && penable && pready;
      xfer_err   <= pslverr;
      xfer_rdata <= prdata;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: the DUT stopped answering APB transfers after %0d cycles", cycles);
         $display("Done: errors found");
         $fatal(1);
      end
   end

   task automatic check_word(string test, string what, word_t exp, word_t got);
      assert (got === exp) else begin
         $display("FAIL %s %s: expected %h, actual %h", test, what, exp, got);
         $display("Done: errors found");
         $fatal(1);
      end
   endtask

   // Entered on a falling edge so transfers run back to back
   task automatic apb_transfer(input logic wr, input logic [APB_AW-1:0] addr,
                               input word_t wdata, output word_t rdata, output logic err);
      psel    = 1'b1; // Setup phase
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clk);
      penable = 1'b1;
      @(negedge clk);
      while (!xfer_done) @(negedge clk); // Held while pready is low
      rdata   = xfer_rdata;
      err     = xfer_err;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_write(input logic [APB_AW-1:0] addr, input word_t data, output logic err);
      word_t unused;
      apb_transfer(1'b1, addr, data, unused, err);
   endtask

   task automatic apb_read(input logic [APB_AW-1:0] addr, output word_t data, output logic err);
      apb_transfer(1'b0, addr, '0, data, err);
   endtask

   // Reference result of one instruction
   function automatic word_t alu_model(op_t op, word_t a, word_t b);
      case (op)
         OP_ADD, OP_ADDI: return a + b;
         OP_SUB:          return a - b;
         OP_AND:          return a & b;
         OP_OR:           return a | b;
         OP_XOR:          return a ^ b;
         OP_SLT:          return (int'(a) < int'(b)) ? 32'd1 : 32'd0;
         OP_MUL:          return a * b; // Low 32 bits
         default:         return '0;
      endcase
   endfunction

   function automatic logic signed [12:0] rand_imm();
      return 13'($urandom());
   endfunction

   task automatic issue_op(string test, op_t op, reg_addr_t rd, reg_addr_t rs1,
                           reg_addr_t rs2, logic signed [12:0] imm);
      instr_t ins;
      word_t  b;
      logic   err;
      ins.op  = op;
      ins.rd  = rd;
      ins.rs1 = rs1;
      ins.rs2 = rs2;
      ins.imm = imm;
      b = (op == OP_ADDI) ? word_t'(int'(imm)) : exp_regs[rs2];
      apb_write(ISSUE_ADDR, word_t'(ins), err);
      check_word(test, "issue pslverr", 32'd0, {31'b0, err});
      if (rd != '0) exp_regs[rd] = alu_model(op, exp_regs[rs1], b);
   endtask

   task automatic check_reg(string test, reg_addr_t r);
      word_t data;
      logic  err;
      apb_read(REG_BASE + {5'b0, r, 2'b00}, data, err);
      check_word(test, "read pslverr", 32'd0, {31'b0, err});
      check_word(test, $sformatf("r%0d", r), exp_regs[r], data);
   endtask

   task automatic test_reset_imm();
      for (int r = 0; r < 32; r++) check_reg("reset_imm", reg_addr_t'(r));
      issue_op("reset_imm", OP_ADDI, 1, 0, 0, -13'sd5);
      issue_op("reset_imm", OP_ADDI, 2, 0, 0, 13'sd4095);
      issue_op("reset_imm", OP_ADDI, 3, 0, 0, 13'h1000); // Most negative immediate
      for (int r = 1; r <= 3; r++) check_reg("reset_imm", reg_addr_t'(r));
   endtask

   task automatic test_alu_ops();
      op_t ops [6] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT};
      for (int round = 0; round < 2; round++) begin
         // r4 non-negative and r5 negative so SLT tells signed from unsigned
         issue_op("alu_ops", OP_ADDI, 4, 0, 0, rand_imm() & 13'h0fff);
         issue_op("alu_ops", OP_ADDI, 5, 0, 0, rand_imm() | 13'h1000);
         for (int i = 0; i < 6; i++) begin
            issue_op("alu_ops", ops[i], reg_addr_t'(10 + i), 4, 5, '0);
            check_reg("alu_ops", reg_addr_t'(10 + i));
         end
         issue_op("alu_ops", OP_SLT, 16, 5, 4, '0); // Operands swapped
         check_reg("alu_ops", 16);
      end
      // Doubling chain widens a small value to the upper bits
      issue_op("alu_ops", OP_ADDI, 17, 0, 0, rand_imm());
      for (int i = 0; i < 8; i++) issue_op("alu_ops", OP_ADD, 17, 17, 17, '0);
      issue_op("alu_ops", OP_OR, 18, 17, 4, '0);
      issue_op("alu_ops", OP_ADD, 19, 18, 17, '0);
      for (int r = 17; r <= 19; r++) check_reg("alu_ops", reg_addr_t'(r));
   endtask

   task automatic test_multiply();
      issue_op("multiply", OP_ADDI, 1, 0, 0, rand_imm());
      issue_op("multiply", OP_ADDI, 2, 0, 0, rand_imm());
      issue_op("multiply", OP_MUL, 3, 1, 2, '0);
      check_reg("multiply", 3); // Stalls until the write-back
      issue_op("multiply", OP_MUL, 7, 3, 3, '0);
      issue_op("multiply", OP_MUL, 8, 17, 4, '0);
      check_reg("multiply", 7);
      check_reg("multiply", 8);
   endtask

   task automatic test_dependent();
      issue_op("dependent", OP_MUL, 20, 1, 2, '0);
      issue_op("dependent", OP_ADD, 21, 20, 1, '0); // Waits on r20
      issue_op("dependent", OP_MUL, 22, 4, 5, '0);
      issue_op("dependent", OP_SUB, 23, 10, 11, '0);
      issue_op("dependent", OP_XOR, 24, 21, 23, '0);
      issue_op("dependent", OP_OR, 25, 22, 24, '0);
      // Independent ALU ops that run into the multiply write-back slot
      issue_op("dependent", OP_MUL, 26, 17, 17, '0);
      issue_op("dependent", OP_ADDI, 27, 1, 0, rand_imm());
      issue_op("dependent", OP_ADDI, 28, 2, 0, rand_imm());
      issue_op("dependent", OP_ADDI, 29, 27, 0, rand_imm());
      for (int r = 20; r <= 29; r++) check_reg("dependent", reg_addr_t'(r));
   endtask

   task automatic test_r0_errors();
      instr_t ins;
      word_t  data;
      logic   err;
      issue_op("r0_errors", OP_ADDI, 0, 0, 0, 13'sd123);
      issue_op("r0_errors", OP_ADD, 0, 1, 2, '0);
      issue_op("r0_errors", OP_MUL, 0, 1, 2, '0);
      check_reg("r0_errors", 0);
      ins = '{op: OP_ADDI, rd: 5'd1, rs1: 5'd0, rs2: 5'd0, imm: 13'sd77};
      apb_write(12'h004, word_t'(ins), err); // Must not issue
      check_word("r0_errors", "bad write pslverr", 32'd1, {31'b0, err});
      apb_read(REG_BASE + 12'h100, data, err);
      check_word("r0_errors", "bad read pslverr", 32'd1, {31'b0, err});
      check_word("r0_errors", "bad read prdata", 32'd0, data);
      for (int r = 0; r < 32; r++) check_reg("r0_errors", reg_addr_t'(r));
   endtask

   initial begin
      if_id_reset = 1'b1;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      for (int r = 0; r < 32; r++) exp_regs[r] = '0;
      void'($urandom(74362));
      repeat (2) @(posedge clk);
      @(negedge clk);
      if_id_reset = 1'b0;
      test_reset_imm();
      test_alu_ops();
      test_multiply();
      test_dependent();
      test_r0_errors();
      $display("Done: no errors");
      $finish;
   end

endmodule

// File: vlog.f
verilog/exec_pkg.sv
verilog/apb_issue_ctrl.sv
verilog/regfile.sv
verilog/alu_stage.sv
verilog/mult_pipe.sv
verilog/exec_core.sv
testbench/tb_exec_core.sv

// File: Bender.yml
package:
  name: exec_core

sources:
  - verilog/exec_pkg.sv
  - verilog/apb_issue_ctrl.sv
  - verilog/regfile.sv
  - verilog/alu_stage.sv
  - verilog/mult_pipe.sv
  - verilog/exec_core.sv
  - target: test
    files:
      - testbench/tb_exec_core.sv
